// File: hdl/noise_pkg.sv
package noise_pkg;

    // signal sample width used by the top level default
    localparam int sig_width_default = 12;

    // inverse-distribution table and histogram size
    localparam int num_bins = 128;
    localparam int bin_width = 7;
    // bin index minus this gives the noise value
    localparam int bin_offset = 63;

    // thresholds compare against the upper bits of the random word
    localparam int thresh_width = 32;
    localparam int hist_width = 8;

    // xorshift state is never allowed to be zero
    localparam logic [63:0] seed_nonzero = 64'h9e37_79b9_7f4a_7c15;

    // host address width and register map byte offsets
    localparam int addr_width = 12;
    localparam logic [addr_width-1:0] reg_ctrl = 12'h000;
    localparam logic [addr_width-1:0] reg_seed_lo = 12'h008;
    localparam logic [addr_width-1:0] reg_seed_hi = 12'h00c;
    // 4 bytes per bin from each base
    localparam logic [addr_width-1:0] reg_thresh_base = 12'h100;
    localparam logic [addr_width-1:0] reg_hist_base = 12'h400;

    // AXI response codes
    typedef enum logic [1:0] {
        axi_okay = 2'b00,
        axi_slverr = 2'b10
    } axi_resp_t;

    // host port FSM
    typedef enum logic [1:0] {
        st_idle,
        st_wresp,
        st_rdata
    } ctrl_state_t;

endpackage

// File: hdl/urng_64.sv
`timescale 1ns/1ps
module urng_64 (
    input  logic        clk,
    input  logic        rstn,
    input  logic        step,
    input  logic        seed_load,
    input  logic [63:0] seed,
    output logic [63:0] rand_word,
    output logic        rand_valid
);
    import noise_pkg::*;

    // one xorshift step: left 13, right 7, left 17
    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // state doubles as the output word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rand_word <= seed_nonzero;
            rand_valid <= 1'b0;
        end else begin
            // word valid one cycle after the request
            rand_valid <= step;
            if (seed_load) begin
                // zero would lock the generator at zero
                if (seed == 64'd0) begin
                    rand_word <= seed_nonzero;
                end else begin
                    rand_word <= seed;
                end
            end else if (step) begin
                rand_word <= xorshift(rand_word);
            end
        end
    end

endmodule

// File: hdl/noise_cdf_lookup.sv
`timescale 1ns/1ps
module noise_cdf_lookup #(
    parameter int THRESH_WIDTH = noise_pkg::thresh_width
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [63:0]             rand_word,
    input  logic                    rand_valid,
    input  logic                    enable,
    input  logic                    thresh_we,
    input  logic [6:0]              thresh_addr,
    input  logic [THRESH_WIDTH-1:0] thresh_data,
    input  logic [6:0]              rd_addr,
    output logic [THRESH_WIDTH-1:0] rd_data,
    output logic [6:0]              bin,
    output logic signed [7:0]       noise,
    output logic                    sample_valid
);
    import noise_pkg::*;

    logic [THRESH_WIDTH-1:0] thresh_mem [num_bins];
    logic [THRESH_WIDTH-1:0] key;
    logic [bin_width-1:0]    hit;
    logic [7:0]              noise_next;

    // upper bits of the random word
    assign key = rand_word[63 -: THRESH_WIDTH];

    // threshold table, all ones after reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < num_bins; i++) begin
                thresh_mem[i] <= '1;
            end
        end else if (thresh_we) begin
            thresh_mem[thresh_addr] <= thresh_data;
        end
    end

    // host read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= thresh_mem[rd_addr];
    end

    // lowest bin whose threshold exceeds the key
    always_comb begin
        // nothing qualifies, clamp to the top bin
        hit = bin_width'(num_bins - 1);
        for (int i = num_bins - 1; i >= 0; i--) begin
            if (thresh_mem[i] > key) begin
                hit = bin_width'(i);
            end
        end
    end

    // bin 0 maps to -63, bin 127 to +64
    assign noise_next = 8'({1'b0, hit}) - 8'(bin_offset);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sample_valid <= 1'b0;
        end else begin
            // only a draw made while enabled counts as a sample
            sample_valid <= rand_valid & enable;
        end
    end

    // result registers
    always_ff @(posedge clk) begin
        bin <= hit;
        // noise forced to zero while disabled
        noise <= enable ? signed'(noise_next) : 8'sd0;
    end

endmodule

// File: hdl/noise_histogram.sv
`timescale 1ns/1ps
module noise_histogram (
    input  logic       clk,
    input  logic       rstn,
    input  logic       count_en,
    input  logic [6:0] bin,
    input  logic       clear,
    input  logic [6:0] rd_addr,
    output logic [7:0] rd_data
);
    import noise_pkg::*;

    logic [hist_width-1:0] count [num_bins];

    // per-bin counters
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < num_bins; i++) begin
                count[i] <= '0;
            end
        end else if (clear) begin
            // clear beats a same-cycle increment
            for (int i = 0; i < num_bins; i++) begin
                count[i] <= '0;
            end
        end else if (count_en) begin
            // wraps past 255
            count[bin] <= count[bin] + 1'b1;
        end
    end

    // registered host read
    always_ff @(posedge clk) begin
        rd_data <= count[rd_addr];
    end

endmodule

// File: hdl/noise_adder.sv
`timescale 1ns/1ps
module noise_adder #(
    parameter int SIG_WIDTH = noise_pkg::sig_width_default
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic signed [SIG_WIDTH-1:0] signal_in,
    input  logic                        signal_valid,
    input  logic signed [7:0]           noise,
    input  logic                        sample_valid,
    output logic signed [SIG_WIDTH-1:0] signal_out,
    output logic                        signal_out_valid
);

    logic signed [SIG_WIDTH-1:0] sig_d1;
    logic signed [SIG_WIDTH-1:0] sig_d2;
    logic                        vld_d1;
    logic                        vld_d2;
    logic signed [7:0]           noise_add;
    logic signed [SIG_WIDTH:0]   sum;
    logic signed [SIG_WIDTH-1:0] sat;

    // two-stage delay to line up with the lookup output
    always_ff @(posedge clk) begin
        sig_d1 <= signal_in;
        sig_d2 <= sig_d1;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_d1 <= 1'b0;
            vld_d2 <= 1'b0;
            signal_out_valid <= 1'b0;
        end else begin
            vld_d1 <= signal_valid;
            vld_d2 <= vld_d1;
            signal_out_valid <= vld_d2;
        end
    end

    // no draw for this sample, add nothing
    assign noise_add = sample_valid ? noise : 8'sd0;

    // one guard bit catches overflow
    assign sum = (SIG_WIDTH+1)'(sig_d2) + (SIG_WIDTH+1)'(noise_add);

    always_comb begin
        sat = sum[SIG_WIDTH-1:0];
        // guard and sign differ on overflow
        if (sum[SIG_WIDTH] != sum[SIG_WIDTH-1]) begin
            // negative overflow to min, positive to max
            sat = sum[SIG_WIDTH] ? {1'b1, {(SIG_WIDTH-1){1'b0}}}
                                 : {1'b0, {(SIG_WIDTH-1){1'b1}}};
        end
    end

    // holds between samples
    always_ff @(posedge clk) begin
        if (vld_d2) begin
            signal_out <= sat;
        end
    end

endmodule

// File: hdl/noise_ctrl.sv
`timescale 1ns/1ps
module noise_ctrl #(
    parameter int THRESH_WIDTH = noise_pkg::thresh_width
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [noise_pkg::addr_width-1:0] awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [31:0]                      wdata,
    input  logic                             wvalid,
    output logic                             wready,
    output noise_pkg::axi_resp_t             bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [noise_pkg::addr_width-1:0] araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [31:0]                      rdata,
    output noise_pkg::axi_resp_t             rresp,
    output logic                             rvalid,
    input  logic                             rready,
    output logic                             enable,
    output logic                             seed_load,
    output logic [63:0]                      seed,
    output logic                             thresh_we,
    output logic [6:0]                       thresh_addr,
    output logic [THRESH_WIDTH-1:0]          thresh_data,
    output logic [6:0]                       thresh_rd_addr,
    input  logic [THRESH_WIDTH-1:0]          thresh_rd_data,
    output logic                             hist_clear,
    output logic [6:0]                       hist_addr,
    input  logic [7:0]                       hist_data
);
    import noise_pkg::*;

    ctrl_state_t           state;
    logic [31:0]           seed_lo;
    logic [31:0]           seed_hi;
    logic [addr_width-1:0] raddr_q;
    logic                  wr_fire;
    logic                  rd_fire;
    logic                  rd_load;
    logic                  w_err;
    logic [31:0]           rd_word;
    logic                  rd_err;

    // word-aligned address inside a 128-entry window
    function automatic logic in_window(input logic [addr_width-1:0] addr,
                                       input logic [addr_width-1:0] base);
        return (addr >= base) && (addr < base + addr_width'(4 * num_bins))
               && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic [6:0] bin_index(input logic [addr_width-1:0] addr,
                                             input logic [addr_width-1:0] base);
        logic [addr_width-1:0] off;
        off = addr - base;
        return off[8:2];
    endfunction

    // handshake cycles
    assign wr_fire = (state == st_idle) && awready && awvalid && wvalid;
    assign rd_fire = (state == st_idle) && arready && arvalid;
    // table and counter data arrive the cycle after the read handshake
    assign rd_load = (state == st_rdata) && !rvalid;

    // table and histogram addressed straight from araddr
    assign thresh_rd_addr = bin_index(araddr, reg_thresh_base);
    assign hist_addr = bin_index(araddr, reg_hist_base);
    assign seed = {seed_hi, seed_lo};

    // histogram is read-only
    assign w_err = !(awaddr == reg_ctrl || awaddr == reg_seed_lo
                     || awaddr == reg_seed_hi || in_window(awaddr, reg_thresh_base));

    // read mux on the latched address
    always_comb begin
        rd_word = '0;
        rd_err = 1'b0;
        if (raddr_q == reg_ctrl) begin
            // clear bit always reads zero
            rd_word = {31'd0, enable};
        end else if (raddr_q == reg_seed_lo) begin
            rd_word = seed_lo;
        end else if (raddr_q == reg_seed_hi) begin
            rd_word = seed_hi;
        end else if (in_window(raddr_q, reg_thresh_base)) begin
            rd_word = 32'(thresh_rd_data);
        end else if (in_window(raddr_q, reg_hist_base)) begin
            rd_word = 32'(hist_data);
        end else begin
            rd_err = 1'b1;
        end
    end

    // FSM, control registers and pulses
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
            awready <= 1'b0;
            wready <= 1'b0;
            arready <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            enable <= 1'b0;
            seed_lo <= seed_nonzero[31:0];
            seed_hi <= seed_nonzero[63:32];
            seed_load <= 1'b0;
            thresh_we <= 1'b0;
            hist_clear <= 1'b0;
        end else begin
            // single-cycle pulses
            seed_load <= 1'b0;
            thresh_we <= 1'b0;
            hist_clear <= 1'b0;
            case (state)
                st_idle: begin
                    if (wr_fire) begin
                        awready <= 1'b0;
                        wready <= 1'b0;
                        bvalid <= 1'b1;
                        state <= st_wresp;
                        if (awaddr == reg_ctrl) begin
                            enable <= wdata[0];
                            hist_clear <= wdata[1];
                        end else if (awaddr == reg_seed_lo) begin
                            seed_lo <= wdata;
                        end else if (awaddr == reg_seed_hi) begin
                            // upper word completes the seed
                            seed_hi <= wdata;
                            seed_load <= 1'b1;
                        end else if (in_window(awaddr, reg_thresh_base)) begin
                            thresh_we <= 1'b1;
                        end
                    end else if (rd_fire) begin
                        arready <= 1'b0;
                        state <= st_rdata;
                    end else if (awvalid && wvalid && !awready && !arready) begin
                        // write wins over a pending read
                        awready <= 1'b1;
                        wready <= 1'b1;
                    end else if (arvalid && !arready && !awready) begin
                        arready <= 1'b1;
                    end
                end
                st_wresp: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state <= st_idle;
                    end
                end
                st_rdata: begin
                    if (rd_load) begin
                        rvalid <= 1'b1;
                    end else if (rready) begin
                        rvalid <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= w_err ? axi_slverr : axi_okay;
            thresh_addr <= bin_index(awaddr, reg_thresh_base);
            thresh_data <= wdata[THRESH_WIDTH-1:0];
        end
        if (rd_fire) begin
            raddr_q <= araddr;
        end
        if (rd_load) begin
            rdata <= rd_word;
            rresp <= rd_err ? axi_slverr : axi_okay;
        end
    end

endmodule

// File: hdl/noise_channel_top.sv
`timescale 1ns/1ps
module noise_channel_top #(
    parameter int SIG_WIDTH = noise_pkg::sig_width_default,
    parameter int THRESH_WIDTH = noise_pkg::thresh_width
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [noise_pkg::addr_width-1:0] awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [31:0]                      wdata,
    input  logic                             wvalid,
    output logic                             wready,
    output noise_pkg::axi_resp_t             bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [noise_pkg::addr_width-1:0] araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [31:0]                      rdata,
    output noise_pkg::axi_resp_t             rresp,
    output logic                             rvalid,
    input  logic                             rready,
    input  logic signed [SIG_WIDTH-1:0]      signal_in,
    input  logic                             signal_valid,
    output logic signed [SIG_WIDTH-1:0]      signal_out,
    output logic                             signal_out_valid
);

    logic                    enable;
    logic                    seed_load;
    logic [63:0]             seed;
    logic                    thresh_we;
    logic [6:0]              thresh_addr;
    logic [THRESH_WIDTH-1:0] thresh_data;
    logic [6:0]              thresh_rd_addr;
    logic [THRESH_WIDTH-1:0] thresh_rd_data;
    logic                    hist_clear;
    logic [6:0]              hist_addr;
    logic [7:0]              hist_data;
    logic                    rand_step;
    logic [63:0]             rand_word;
    logic                    rand_valid;
    logic [6:0]              bin;
    logic signed [7:0]       noise;
    logic                    sample_valid;

    // one draw per valid sample while enabled
    assign rand_step = signal_valid & enable;

    noise_ctrl #(.THRESH_WIDTH(THRESH_WIDTH)) u_ctrl (
        .clk(clk), .rstn(rstn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .enable(enable), .seed_load(seed_load), .seed(seed),
        .thresh_we(thresh_we), .thresh_addr(thresh_addr), .thresh_data(thresh_data),
        .thresh_rd_addr(thresh_rd_addr), .thresh_rd_data(thresh_rd_data),
        .hist_clear(hist_clear), .hist_addr(hist_addr), .hist_data(hist_data)
    );

    urng_64 u_urng (
        .clk(clk), .rstn(rstn),
        .step(rand_step), .seed_load(seed_load), .seed(seed),
        .rand_word(rand_word), .rand_valid(rand_valid)
    );

    noise_cdf_lookup #(.THRESH_WIDTH(THRESH_WIDTH)) u_lookup (
        .clk(clk), .rstn(rstn),
        .rand_word(rand_word), .rand_valid(rand_valid), .enable(enable),
        .thresh_we(thresh_we), .thresh_addr(thresh_addr), .thresh_data(thresh_data),
        .rd_addr(thresh_rd_addr), .rd_data(thresh_rd_data),
        .bin(bin), .noise(noise), .sample_valid(sample_valid)
    );

    // sample_valid already carries the registered enable
    noise_histogram u_hist (
        .clk(clk), .rstn(rstn),
        .count_en(sample_valid), .bin(bin), .clear(hist_clear),
        .rd_addr(hist_addr), .rd_data(hist_data)
    );

    noise_adder #(.SIG_WIDTH(SIG_WIDTH)) u_adder (
        .clk(clk), .rstn(rstn),
        .signal_in(signal_in), .signal_valid(signal_valid),
        .noise(noise), .sample_valid(sample_valid),
        .signal_out(signal_out), .signal_out_valid(signal_out_valid)
    );

endmodule

// File: sim/noise_channel_asserts.sv
`timescale 1ns/1ps
module noise_channel_asserts (
    input logic clk,
    input logic rstn,
    input logic signal_valid,
    input logic signal_out_valid,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    // read back by the testbench at the end
    int assert_failures = 0;

    // fixed three-stage sample path
    sample_latency: assert property (@(posedge clk) disable iff (!rstn)
        signal_out_valid == $past(signal_valid, 3))
    else begin
        assert_failures++;
        $error("output valid not exactly 3 cycles after input valid");
    end

    // address and data accepted together
    aw_w_together: assert property (@(posedge clk) disable iff (!rstn) awready == wready)
    else begin
        assert_failures++;
        $error("awready and wready differ");
    end

    b_hold: assert property (@(posedge clk) disable iff (!rstn) bvalid && !bready |=> bvalid)
    else begin
        assert_failures++;
        $error("bvalid dropped before bready");
    end

    r_hold: assert property (@(posedge clk) disable iff (!rstn) rvalid && !rready |=> rvalid)
    else begin
        assert_failures++;
        $error("rvalid dropped before rready");
    end

endmodule

bind noise_channel_top noise_channel_asserts u_asserts (
    .clk(clk), .rstn(rstn),
    .signal_valid(signal_valid), .signal_out_valid(signal_out_valid),
    .awready(awready), .wready(wready),
    .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready)
);

// File: sim/noise_channel_tb.sv
`timescale 1ns/1ps
module noise_channel_tb;
    import noise_pkg::*;

    localparam int sig_width = sig_width_default;

    typedef enum {op_write, op_read, op_signal, op_wait} op_kind_t;

    logic                        clk;
    logic                        rstn;
    logic [addr_width-1:0]       awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [31:0]                 wdata;
    logic                        wvalid;
    logic                        wready;
    axi_resp_t                   bresp;
    logic                        bvalid;
    logic                        bready;
    logic [addr_width-1:0]       araddr;
    logic                        arvalid;
    logic                        arready;
    logic [31:0]                 rdata;
    axi_resp_t                   rresp;
    logic                        rvalid;
    logic                        rready;
    logic signed [sig_width-1:0] signal_in;
    logic                        signal_valid;
    logic signed [sig_width-1:0] signal_out;
    logic                        signal_out_valid;

    // parsed trace, one entry per line
    op_kind_t op_kind_q[$];
    int       op_a_q[$];
    int       op_b_q[$];
    int       op_c_q[$];
    int       op_d_q[$];
    // outputs still owed by the DUT, oldest first
    logic signed [sig_width-1:0] exp_q[$];
    logic [31:0] lfsr = 32'h8cc4_e8a0;
    int cycles = 0;
    int cycle_limit = 0;

    noise_channel_top #(.SIG_WIDTH(sig_width), .THRESH_WIDTH(thresh_width)) dut0 (
        .clk(clk), .rstn(rstn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .signal_in(signal_in), .signal_valid(signal_valid),
        .signal_out(signal_out), .signal_out_valid(signal_out_valid)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp, input axi_resp_t got_resp,
                                input axi_resp_t exp_resp);
        if (got !== exp || got_resp !== exp_resp) begin
            $display("mismatch at %0t: %s got %h %s expected %h %s", $time, what,
                     got, got_resp.name(), exp, exp_resp.name());
            abort_run();
        end
    endtask

    task automatic compare_sample(input logic signed [sig_width-1:0] got,
                                  input logic signed [sig_width-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: signal_out got %0d expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    // galois form, taps b4bcd35c
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
    endfunction

    // idle gap of 0 to 3 cycles, two bits
    task automatic pick_gap(output int gap);
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            gap = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    // entered and left on a falling edge
    task automatic axi_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                             input axi_resp_t exp_resp);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!awready) @(negedge clk);
        // handshake on the rising edge in between
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) @(negedge clk);
        // no data comes back on a write
        compare_word($sformatf("write %h bresp", addr), 32'd0, 32'd0, bresp, exp_resp);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [addr_width-1:0] addr, input logic [31:0] exp,
                            input axi_resp_t exp_resp);
        // araddr held past the handshake for the registered table read
        araddr = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        compare_word($sformatf("read %h", addr), rdata, exp, rresp, exp_resp);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic issue_sample(input int value, input int expected);
        int gap;
        signal_in = sig_width'(value);
        signal_valid = 1'b1;
        exp_q.push_back(sig_width'(expected));
        @(negedge clk);
        signal_valid = 1'b0;
        // valid stays high when the next sample follows at once
        pick_gap(gap);
        repeat (gap) @(negedge clk);
    endtask

    // let in-flight samples leave before touching registers
    task automatic drain_samples();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic push_op(input op_kind_t kind, input int a, input int b, input int c,
                           input int d, input bit ok);
        if (!ok) begin
            $display("error: malformed trace line of kind %s", kind.name());
            abort_run();
        end
        op_kind_q.push_back(kind);
        op_a_q.push_back(a);
        op_b_q.push_back(b);
        op_c_q.push_back(c);
        op_d_q.push_back(d);
    endtask

    task automatic load_trace(output int units);
        int fd;
        int n;
        int a;
        int b;
        int c;
        int d;
        string line;
        string kind;
        units = 0;
        fd = $fopen("sim/noise_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the trace file sim/noise_trace.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", kind);
            // skip blank and comment lines
            if (n == 1 && kind.getc(0) != "#") begin
                if (kind == "write") begin
                    n = $sscanf(line, "%s %h %h %d %d", kind, a, b, c, d);
                    push_op(op_write, a, b, c, d, n == 5);
                    units += c;
                end else if (kind == "read") begin
                    n = $sscanf(line, "%s %h %h %d", kind, a, b, d);
                    push_op(op_read, a, b, 1, d, n == 4);
                    units += 1;
                end else if (kind == "signal") begin
                    n = $sscanf(line, "%s %d %d", kind, a, b);
                    push_op(op_signal, a, b, 0, 0, n == 3);
                    units += 1;
                end else if (kind == "wait") begin
                    n = $sscanf(line, "%s %d", kind, a);
                    push_op(op_wait, a, 0, 0, 0, n == 2);
                    units += 1 + a;
                end else begin
                    $display("error: unknown trace line kind %s", kind);
                    abort_run();
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_op(input int i);
        case (op_kind_q[i])
            op_write: begin
                drain_samples();
                // count > 1 fills consecutive words
                for (int k = 0; k < op_c_q[i]; k++) begin
                    axi_write(addr_width'(op_a_q[i] + 4 * k), op_b_q[i],
                              axi_resp_t'(2'(op_d_q[i])));
                end
            end
            op_read: begin
                drain_samples();
                axi_read(addr_width'(op_a_q[i]), op_b_q[i], axi_resp_t'(2'(op_d_q[i])));
            end
            op_signal: issue_sample(op_a_q[i], op_b_q[i]);
            op_wait: repeat (op_a_q[i]) @(negedge clk);
            default: begin
                $display("error: trace entry %0d has no known kind", i);
                abort_run();
            end
        endcase
    endtask

    // outputs checked away from the rising edge
    always @(negedge clk) begin
        if (rstn && signal_out_valid) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: output sample arrived with none pending", $time);
                abort_run();
            end else begin
                compare_sample(signal_out, exp_q.pop_front());
            end
        end
    end

    // run limit from the trace length
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("error: run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        int units;
        clk = 1'b0;
        rstn = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        signal_in = '0;
        signal_valid = 1'b0;
        load_trace(units);
        cycle_limit = 20 * units + 40;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        for (int i = 0; i < op_kind_q.size(); i++) begin
            run_op(i);
        end
        drain_samples();
        repeat (4) @(negedge clk);
        if (dut0.u_asserts.assert_failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("error: %0d assertion failures", dut0.u_asserts.assert_failures);
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sim/noise_trace.txt
# write <addr> <data> <count> <resp>, read <addr> <data> <resp>; hex, resp 0 okay 2 slverr
# signal <in> <expected out> in signed decimal, wait <cycles>
# register access
write 114 12345678 1 0
read 114 12345678 0
read 2fc ffffffff 0
write 0 2 1 0
read 0 0 0
read 10 0 2
write 404 1 1 2
write 20 5 1 2
# enable low, samples pass unchanged
signal 0 0
signal 1234 1234
signal -2048 -2048
signal 2047 2047
signal -5 -5
wait 3
# bins 0 to 69 zero, every draw lands in bin 70
write 100 0 70 0
write 0 1 1 0
signal 0 7
signal -100 -93
signal 2040 2047
signal 2046 2047
signal -2048 -2041
signal 500 507
# split at 2^31 between bins 10 and 11, seed 00000002_00000000
write 128 80000000 1 0
write 12c ffffffff 1 0
write 8 0 1 0
write c 2 1 0
signal 100 48
signal 100 47
signal -2000 -2048
signal 0 -52
signal 60 8
# histogram, then clear with enable kept
read 518 6 0
read 428 2 0
read 42c 3 0
write 0 3 1 0
read 518 0 0
read 428 0 0
read 0 1 0

// File: vlog.f
hdl/noise_pkg.sv
hdl/urng_64.sv
hdl/noise_cdf_lookup.sv
hdl/noise_histogram.sv
hdl/noise_adder.sv
hdl/noise_ctrl.sv
hdl/noise_channel_top.sv
sim/noise_channel_asserts.sv
sim/noise_channel_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= noise_channel_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
